//--- common/intt_pkg.sv
// ring constants, data types, sequencer states and the twiddle power function
package intt_pkg;

    localparam int COEF_W     = 13;                 // one coefficient word
    localparam int Q          = 7681;               // prime modulus
    localparam int RING_DEPTH = 4;
    localparam int RING_SIZE  = 1 << RING_DEPTH;    // 16 coefficients
    localparam int N_INV      = 7201;               // 16 * 7201 = 1 mod q

    // 62 has order 512 mod q, so 62^32 = 7154 has order 16
    // forward root is 7098, this is its inverse
    localparam int OMEGA_INV  = 7154;

    localparam int TW_W       = RING_DEPTH - 1;     // exponent index bits
    localparam int TW_SIZE    = RING_SIZE / 2;      // powers 0..7
    localparam int BF_LATENCY = 3;                  // butterfly pipeline depth

    // barrett constants for the product reduction
    localparam int PROD_W     = 2 * COEF_W;
    localparam int BARRETT_MU = (1 << PROD_W) / Q;  // floor(2^26 / q)

    typedef logic [COEF_W-1:0]     coef_t;
    typedef logic [RING_DEPTH-1:0] addr_t;
    typedef logic [TW_W-1:0]       tw_idx_t;

    typedef enum logic [2:0] {
        IDLE,   // waits for a command strobe
        LOAD,   // 16 words in from din
        STAGE,  // 8 butterflies per stage
        DRAIN,  // lets write-back catch up
        SCALE,  // multiply by n^-1
        READ    // 16 words out on dout
    } seq_state_t;

    // omega_inv ^ power mod q, by repeated multiply
    function automatic coef_t omega_pow(input int unsigned power);
        int unsigned acc;
        acc = 1;
        for (int unsigned i = 0; i < power; i++) begin
            acc = (acc * OMEGA_INV) % Q;    // stays below 2^26
        end
        return coef_t'(acc);
    endfunction

endpackage

//--- logic/coef_ram.sv
// 16-word coefficient store, two registered read ports and two write ports
`timescale 1ns/1ns

module coef_ram (
    input  logic            clk,
    input  intt_pkg::addr_t rd_addr0,
    input  intt_pkg::addr_t rd_addr1,
    input  logic            wr_en0,
    input  logic            wr_en1,
    input  intt_pkg::addr_t wr_addr0,
    input  intt_pkg::addr_t wr_addr1,
    input  intt_pkg::coef_t wr_data0,
    input  intt_pkg::coef_t wr_data1,
    output intt_pkg::coef_t rd_data0,
    output intt_pkg::coef_t rd_data1
);
    import intt_pkg::*;

    coef_t mem [RING_SIZE];  // whole polynomial

    // butterfly writes u and v to distinct addresses
    always_ff @(posedge clk) begin
        if (wr_en0) begin
            mem[wr_addr0] <= wr_data0;
        end
        if (wr_en1) begin
            mem[wr_addr1] <= wr_data1;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data0 <= mem[rd_addr0];
        rd_data1 <= mem[rd_addr1];
    end

endmodule

//--- logic/intt_top.sv
// top level with sequencer, coefficient memory, butterfly and twiddle table
`timescale 1ns/1ns

module intt_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_data,
    input  intt_pkg::coef_t din,
    input  logic            start_intt,
    input  logic            output_data_single,
    output logic            done,
    output intt_pkg::coef_t dout
);
    import intt_pkg::*;

    // memory ports
    addr_t   rd_addr0;
    addr_t   rd_addr1;
    coef_t   rd_data0;
    coef_t   rd_data1;
    logic    wr_en0;
    logic    wr_en1;
    addr_t   wr_addr0;
    addr_t   wr_addr1;
    coef_t   wr_data0;
    coef_t   wr_data1;

    // butterfly and twiddle path
    tw_idx_t tw_idx;
    coef_t   tw_value;
    coef_t   bf_u;
    coef_t   bf_v;
    coef_t   bf_w;
    coef_t   bf_sum;
    coef_t   bf_diff;

    intt_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .load_data          (load_data),
        .din                (din),
        .start_intt         (start_intt),
        .output_data_single (output_data_single),
        .rd_data0           (rd_data0),
        .rd_data1           (rd_data1),
        .bf_sum             (bf_sum),
        .bf_diff            (bf_diff),
        .tw_value           (tw_value),
        .done               (done),
        .dout               (dout),
        .rd_addr0           (rd_addr0),
        .rd_addr1           (rd_addr1),
        .wr_en0             (wr_en0),
        .wr_en1             (wr_en1),
        .wr_addr0           (wr_addr0),
        .wr_addr1           (wr_addr1),
        .wr_data0           (wr_data0),
        .wr_data1           (wr_data1),
        .tw_idx             (tw_idx),
        .bf_u               (bf_u),
        .bf_v               (bf_v),
        .bf_w               (bf_w)
    );

    coef_ram u_ram (
        .clk      (clk),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .wr_en0   (wr_en0),
        .wr_en1   (wr_en1),
        .wr_addr0 (wr_addr0),
        .wr_addr1 (wr_addr1),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    gs_butterfly u_bf (
        .clk   (clk),
        .reset (reset),
        .u     (bf_u),
        .v     (bf_v),
        .w     (bf_w),
        .sum   (bf_sum),
        .diff  (bf_diff)
    );

    twiddle_rom u_tw (
        .clk      (clk),
        .tw_idx   (tw_idx),
        .tw_value (tw_value)
    );

endmodule

//--- ntt_core/gs_butterfly.sv
// pipelined gentleman-sande butterfly mod q, sum and twiddled difference
`timescale 1ns/1ns

module gs_butterfly (
    input  logic            clk,
    input  logic            reset,
    input  intt_pkg::coef_t u,
    input  intt_pkg::coef_t v,
    input  intt_pkg::coef_t w,
    output intt_pkg::coef_t sum,
    output intt_pkg::coef_t diff
);
    import intt_pkg::*;

    logic [COEF_W:0]          add_raw;   // u + v with carry
    coef_t                    add_mod;
    coef_t                    sub_mod;
    coef_t                    sum_s1;
    coef_t                    diff_s1;
    coef_t                    w_s1;
    coef_t                    sum_s2;
    logic [PROD_W-1:0]        prod_s2;   // full (u - v) * w
    logic [PROD_W+COEF_W:0]   bar_full;  // product times mu
    logic [COEF_W:0]          quot;      // quotient estimate
    logic [COEF_W+1:0]        rem_a;     // below 3q
    logic [COEF_W+1:0]        rem_b;     // below 2q
    coef_t                    red;

    always_comb begin
        add_raw = u + v;
        add_mod = (add_raw >= Q) ? coef_t'(add_raw - Q) : coef_t'(add_raw);
        sub_mod = (u >= v) ? coef_t'(u - v) : coef_t'(u + Q - v);  // wrap negative
    end

    // barrett reduction, estimate is short by at most 2
    always_comb begin
        bar_full = prod_s2 * (COEF_W + 1)'(BARRETT_MU);
        quot     = bar_full[PROD_W +: COEF_W + 1];
        rem_a    = (COEF_W + 2)'(prod_s2 - quot * Q);
        rem_b    = (rem_a >= Q) ? (COEF_W + 2)'(rem_a - Q) : rem_a;
        red      = (rem_b >= Q) ? coef_t'(rem_b - Q) : coef_t'(rem_b);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_s1  <= '0;
            diff_s1 <= '0;
            w_s1    <= '0;
            sum_s2  <= '0;
            prod_s2 <= '0;
            sum     <= '0;
            diff    <= '0;
        end else begin
            sum_s1  <= add_mod;  // add / sub
            diff_s1 <= sub_mod;
            w_s1    <= w;
            sum_s2  <= sum_s1;   // multiply
            prod_s2 <= diff_s1 * w_s1;
            sum     <= sum_s2;   // reduce
            diff    <= red;
        end
    end

endmodule

//--- ntt_core/intt_ctrl.sv
// sequencer for load, butterfly stages, scaling and readout with write-back alignment
`timescale 1ns/1ns

module intt_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_data,
    input  intt_pkg::coef_t   din,
    input  logic              start_intt,
    input  logic              output_data_single,
    input  intt_pkg::coef_t   rd_data0,
    input  intt_pkg::coef_t   rd_data1,
    input  intt_pkg::coef_t   bf_sum,
    input  intt_pkg::coef_t   bf_diff,
    input  intt_pkg::coef_t   tw_value,
    output logic              done,
    output intt_pkg::coef_t   dout,
    output intt_pkg::addr_t   rd_addr0,
    output intt_pkg::addr_t   rd_addr1,
    output logic              wr_en0,
    output logic              wr_en1,
    output intt_pkg::addr_t   wr_addr0,
    output intt_pkg::addr_t   wr_addr1,
    output intt_pkg::coef_t   wr_data0,
    output intt_pkg::coef_t   wr_data1,
    output intt_pkg::tw_idx_t tw_idx,
    output intt_pkg::coef_t   bf_u,
    output intt_pkg::coef_t   bf_v,
    output intt_pkg::coef_t   bf_w
);
    import intt_pkg::*;

    seq_state_t state;
    addr_t      cnt;        // cycle within the current state
    logic [2:0] stage_cnt;  // 0..3 butterfly stages, 4 is scaling

    // pair addressing for the current stage
    addr_t      half_span;  // m = 8 >> s
    addr_t      lo_mask;
    addr_t      pair_idx;
    addr_t      pair_u;
    addr_t      pair_v;
    tw_idx_t    pair_tw;

    // issue stage, lines up with the memory read register
    logic       iss_en0;
    logic       iss_en1;
    logic       iss_scale;
    addr_t      iss_addr0;
    addr_t      iss_addr1;

    // write-back delay line through the butterfly
    logic [BF_LATENCY-1:0] en0_sr;
    logic [BF_LATENCY-1:0] en1_sr;
    addr_t                 addr0_sr [BF_LATENCY];
    addr_t                 addr1_sr [BF_LATENCY];

    always_comb begin
        half_span = addr_t'(RING_SIZE / 2) >> stage_cnt;
        lo_mask   = half_span - 1'b1;
        pair_idx  = {1'b0, cnt[TW_W-1:0]};                          // butterfly p
        pair_u    = ((pair_idx & ~lo_mask) << 1) | (pair_idx & lo_mask); // group*2m + j
        pair_v    = pair_u | half_span;                             // u + m
        pair_tw   = tw_idx_t'(cnt[TW_W-1:0] & lo_mask[TW_W-1:0]) << stage_cnt; // j << s
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            cnt       <= '0;
            stage_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    cnt       <= '0;
                    stage_cnt <= '0;
                    if (output_data_single) begin  // readout wins
                        state <= READ;
                    end else if (load_data) begin
                        state <= LOAD;
                    end else if (start_intt) begin
                        state <= STAGE;
                    end
                end
                LOAD, READ: begin
                    cnt <= cnt + 1'b1;  // wraps back to 0
                    if (cnt == addr_t'(RING_SIZE - 1)) begin
                        state <= IDLE;
                    end
                end
                STAGE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == addr_t'(RING_SIZE / 2 - 1)) begin
                        cnt   <= '0;
                        state <= DRAIN;
                    end
                end
                SCALE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == addr_t'(RING_SIZE - 1)) begin
                        cnt   <= '0;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == addr_t'(BF_LATENCY)) begin  // last write-back has landed
                        cnt <= '0;
                        if (stage_cnt == 3'(RING_DEPTH)) begin
                            done  <= 1'b1;
                            state <= IDLE;
                        end else begin
                            stage_cnt <= stage_cnt + 1'b1;
                            state     <= (stage_cnt == 3'(RING_DEPTH - 1)) ? SCALE : STAGE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read side, one cycle ahead of the butterfly
    always_comb begin
        rd_addr0 = '0;  // idle default also primes word 0 for readout
        rd_addr1 = '0;
        case (state)
            STAGE: begin
                rd_addr0 = pair_u;
                rd_addr1 = pair_v;
            end
            SCALE: rd_addr0 = cnt;
            READ:  rd_addr0 = cnt + 1'b1;  // word 0 was read in idle
            default: ;
        endcase
        tw_idx = (state == STAGE) ? pair_tw : '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iss_en0   <= 1'b0;
            iss_en1   <= 1'b0;
            iss_scale <= 1'b0;
            en0_sr    <= '0;
            en1_sr    <= '0;
        end else begin
            iss_en0   <= (state == STAGE);                     // sum goes back to u
            iss_en1   <= (state == STAGE) || (state == SCALE); // diff goes back to v
            iss_scale <= (state == SCALE);
            en0_sr    <= {en0_sr[BF_LATENCY-2:0], iss_en0};
            en1_sr    <= {en1_sr[BF_LATENCY-2:0], iss_en1};
        end
    end

    always_ff @(posedge clk) begin
        iss_addr0   <= pair_u;
        iss_addr1   <= (state == SCALE) ? cnt : pair_v;  // scaled word stays in place
        addr0_sr[0] <= iss_addr0;
        addr1_sr[0] <= iss_addr1;
        for (int i = 1; i < BF_LATENCY; i++) begin
            addr0_sr[i] <= addr0_sr[i-1];
            addr1_sr[i] <= addr1_sr[i-1];
        end
    end

    // butterfly operands straight from the memory and rom registers
    assign bf_u = rd_data0;
    assign bf_v = iss_scale ? '0 : rd_data1;  // v = 0 turns diff into u * w
    assign bf_w = iss_scale ? coef_t'(N_INV) : tw_value;

    // port 0 shared between load and write-back
    assign wr_en0   = (state == LOAD) || en0_sr[BF_LATENCY-1];
    assign wr_addr0 = (state == LOAD) ? cnt : addr0_sr[BF_LATENCY-1];
    assign wr_data0 = (state == LOAD) ? din : bf_sum;
    assign wr_en1   = en1_sr[BF_LATENCY-1];
    assign wr_addr1 = addr1_sr[BF_LATENCY-1];
    assign wr_data1 = bf_diff;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else begin
            dout <= (state == READ) ? rd_data0 : '0;  // zero outside the window
        end
    end

endmodule

//--- ntt_core/twiddle_rom.sv
// registered table of inverse root powers 0..7
`timescale 1ns/1ns

module twiddle_rom (
    input  logic              clk,
    input  intt_pkg::tw_idx_t tw_idx,
    output intt_pkg::coef_t   tw_value
);
    import intt_pkg::*;

    coef_t tw_tab [TW_SIZE];

    // constant entries, folded at elaboration
    for (genvar i = 0; i < TW_SIZE; i++) begin : g_tab
        assign tw_tab[i] = omega_pow(i);
    end

    always_ff @(posedge clk) begin
        tw_value <= tw_tab[tw_idx];  // one cycle like the coefficient reads
    end

endmodule

//--- verif/intt_checker.sv
// sequencer assertions for the done pulse, write enables and state, with its bind
`timescale 1ns/1ns

module intt_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 load_data,
    input logic                 start_intt,
    input logic                 output_data_single,
    input logic                 done,
    input logic                 wr_en0,
    input logic                 wr_en1,
    input intt_pkg::seq_state_t state
);
    import intt_pkg::*;

    // done is a one-cycle strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high on two consecutive cycles");

    // memory untouched while waiting for a command
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !(wr_en0 || wr_en1))
        else $error("a write enable was high in the idle state");

    // no command pending, so the sequencer rests after done
    a_done_idle: assert property (@(posedge clk) disable iff (reset)
        done && !(load_data || start_intt || output_data_single) |=> (state == IDLE))
        else $error("the sequencer left the idle state after done without a command");

    // readout only reads
    a_read_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == READ) |-> !(wr_en0 || wr_en1))
        else $error("a write enable was high during readout");

endmodule

bind intt_ctrl intt_checker u_checker (
    .clk                (clk),
    .reset              (reset),
    .load_data          (load_data),
    .start_intt         (start_intt),
    .output_data_single (output_data_single),
    .done               (done),
    .wr_en0             (wr_en0),
    .wr_en1             (wr_en1),
    .state              (state)
);

//--- verif/intt_tb.sv
// testbench for the inverse ntt engine, seeded random vectors against a direct model
`timescale 1ns/1ns

module intt_tb;
    import intt_pkg::*;

    localparam int TIMEOUT_CYCLES = 8 * (18 + 150 + 20) * 2;  // 8 tests, generous

    logic        clk;
    logic        reset;
    logic        load_data;
    coef_t       din;
    logic        start_intt;
    logic        output_data_single;
    logic        done;
    coef_t       dout;

    coef_t       vec [RING_SIZE];          // input polynomial, standard order
    coef_t       exp_word [RING_SIZE];     // expected words in readout order
    coef_t       rd_words [RING_SIZE];
    int          checks;
    int          errors;
    int          cycle_cnt = 0;
    int unsigned seed;

    intt_top uut (
        .clk                (clk),
        .reset              (reset),
        .load_data          (load_data),
        .din                (din),
        .start_intt         (start_intt),
        .output_data_single (output_data_single),
        .done               (done),
        .dout               (dout)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // hard stop if done never shows up
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare_coef(input string what, input addr_t idx, input coef_t got,
                                input coef_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s word %0d got %0d expected %0d",
                     $time, what, idx, got, exp);
        end
    endtask

    task automatic check_done(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s done got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic addr_t bit_reverse(input addr_t a);
        addr_t r;
        for (int b = 0; b < RING_DEPTH; b++) begin
            r[b] = a[RING_DEPTH-1-b];
        end
        return r;
    endfunction

    // direct O(n^2) inverse transform, then scrambled order
    task automatic build_expected();
        int unsigned acc;
        int unsigned spec [RING_SIZE];
        for (int j = 0; j < RING_SIZE; j++) begin
            acc = 0;
            for (int i = 0; i < RING_SIZE; i++) begin
                acc = (acc + vec[i] * omega_pow((i * j) % RING_SIZE)) % Q;
            end
            spec[j] = (acc * N_INV) % Q;  // 1/n scaling
        end
        for (int k = 0; k < RING_SIZE; k++) begin
            exp_word[k] = coef_t'(spec[bit_reverse(addr_t'(k))]);
        end
    endtask

    // strobe, then one word per cycle
    task automatic load_vector();
        load_data = 1'b1;
        for (int i = 0; i < RING_SIZE; i++) begin
            @(negedge clk);
            load_data = 1'b0;
            din       = vec[i];
        end
        @(negedge clk);
        din = '0;
    endtask

    task automatic run_transform(input bit poke_busy);
        int waited;
        start_intt = 1'b1;
        @(negedge clk);
        start_intt = 1'b0;
        waited     = 0;
        while (done !== 1'b1) begin
            load_data  = poke_busy && (waited == 5);   // must be ignored
            start_intt = poke_busy && (waited == 17);
            din        = coef_t'($urandom % Q);        // junk that must not land
            @(negedge clk);
            waited++;
        end
        load_data  = 1'b0;
        start_intt = 1'b0;
        din        = '0;
        repeat (6) begin  // no second pulse
            @(negedge clk);
            check_done("after done", done, 1'b0);
        end
    endtask

    // word k appears two cycles after the strobe plus k
    task automatic read_words();
        output_data_single = 1'b1;
        @(negedge clk);
        output_data_single = 1'b0;
        compare_coef("dout before window", '0, dout, '0);
        for (int k = 0; k < RING_SIZE; k++) begin
            @(negedge clk);
            rd_words[k] = dout;
        end
        @(negedge clk);
        compare_coef("dout after window", '0, dout, '0);
    endtask

    task automatic check_words();
        for (int k = 0; k < RING_SIZE; k++) begin
            compare_coef("readout", addr_t'(k), rd_words[k], exp_word[k]);
        end
    endtask

    initial begin
        reset              = 1'b1;
        load_data          = 1'b0;
        din                = '0;
        start_intt         = 1'b0;
        output_data_single = 1'b0;
        checks             = 0;
        errors             = 0;
        seed               = 32'h155a_f03b;
        void'($urandom(seed));
        repeat (5) @(negedge clk);
        reset = 1'b0;

        repeat (6) begin  // quiet before any command
            @(negedge clk);
            check_done("idle after reset", done, 1'b0);
            compare_coef("idle dout", '0, dout, '0);
        end

        // impulse, every bin is n^-1
        for (int i = 0; i < RING_SIZE; i++) begin
            vec[i]      = (i == 0) ? coef_t'(1) : '0;
            exp_word[i] = coef_t'(N_INV);
        end
        load_vector();
        run_transform(1'b0);
        read_words();
        check_words();

        for (int t = 0; t < 6; t++) begin
            for (int i = 0; i < RING_SIZE; i++) begin
                vec[i] = coef_t'($urandom % Q);
            end
            build_expected();
            load_vector();
            run_transform(t == 5);  // last vector sees stray commands
            read_words();
            check_words();
            if (t == 0) begin  // back-to-back readout repeats
                read_words();
                for (int k = 0; k < RING_SIZE; k++) begin
                    compare_coef("repeat readout", addr_t'(k), rd_words[k], exp_word[k]);
                end
            end
        end

        // sparse vector exposes any leftover of the previous one
        for (int i = 0; i < RING_SIZE; i++) begin
            vec[i] = '0;
        end
        vec[5] = coef_t'(1 + $urandom % (Q - 1));
        build_expected();
        load_vector();
        run_transform(1'b0);
        read_words();
        check_words();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/intt_pkg.sv
logic/coef_ram.sv
ntt_core/gs_butterfly.sv
ntt_core/twiddle_rom.sv
ntt_core/intt_ctrl.sv
logic/intt_top.sv
verif/intt_checker.sv
verif/intt_tb.sv
